// ==== drain_subsys_top.f ====
design/drain_pkg.sv
design/drain_cmd_decode.sv
design/drain_reserve_seq.sv
design/drain_ctrl.sv
design/drain_burst_result.sv
design/drain_subsys_top.sv
tests/drain_subsys_tb.sv

// ==== Makefile ====
# Verilator build for the drain subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TB_TOP    := drain_subsys_tb
RTL_TOP   := drain_subsys_top
FILELIST  := drain_subsys_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/drain_subsys_tb.sv ====
// Drain subsystem testbench
`timescale 1ns/100ps

module drain_subsys_tb;

    localparam int DEPTH = 16;
    localparam int AW    = $clog2(DEPTH);

    logic                            axi_aclk;
    logic                            rst_n;
    logic                            beat_valid;
    logic                            cmd_valid;
    drain_pkg::drain_op_e            cmd_op;
    logic [drain_pkg::LEN_W-1:0]     cmd_len;
    logic                            beat_ready;
    logic [AW:0]                     data_available;
    logic                            wr_full;
    logic                            wr_almost_full;
    logic                            rd_empty;
    logic                            rd_almost_empty;
    logic                            busy;
    logic                            cmd_error;
    logic                            burst_done;
    logic [drain_pkg::LEN_W-1:0]     burst_len;
    logic [drain_pkg::BURSTS_W-1:0]  bursts_total;
    logic [drain_pkg::BEATS_W-1:0]   beats_total;

    int errors;
    int test_base;
    int tests_run;
    int beat_pct;                                       // Beat strobe rate in percent
    bit hung;                                           // Set by any wait that timed out

    drain_subsys_top #(
        .DEPTH            (DEPTH),
        .ALMOST_WR_MARGIN (2),
        .ALMOST_RD_MARGIN (2)
    ) uut (.*);

    always #2 axi_aclk = ~axi_aclk;                     // 4 ns period

    // Random beat source
    always @(posedge axi_aclk) beat_valid <= (($urandom % 100) < beat_pct);

    // ------------------------------------------------------------------------
    // Reference model from the timing rules
    // ------------------------------------------------------------------------
    logic [AW:0]                     m_occ;             // Expected occupancy
    logic                            m_busy;
    logic [drain_pkg::LEN_W-1:0]     m_len;             // Last accepted request length
    logic                            exp_req;
    logic [drain_pkg::LEN_W-1:0]     exp_req_len;
    logic                            exp_clr;
    logic                            exp_err;
    logic                            exp_done;
    logic [drain_pkg::LEN_W-1:0]     exp_blen;
    logic [drain_pkg::BURSTS_W-1:0]  m_bursts;
    logic [drain_pkg::BEATS_W-1:0]   m_beats;
    logic                            m_drain;           // Drain expected this cycle
    logic                            beat_in;
    logic                            blocked;
    logic                            len_ok;
    logic                            exp_full;
    logic                            exp_afull;
    logic                            exp_empty;
    logic                            exp_aempty;

    assign m_drain    = m_busy && (32'(m_occ) >= 32'(m_len));
    assign beat_in    = beat_valid && (32'(m_occ) != DEPTH);
    assign blocked    = m_busy || exp_req;
    assign len_ok     = (cmd_len != '0) && (32'(cmd_len) <= DEPTH);
    assign exp_full   = (32'(m_occ) == DEPTH);
    assign exp_afull  = (32'(m_occ) >= DEPTH - 2);     // Two below full
    assign exp_empty  = (m_occ == '0);
    assign exp_aempty = (32'(m_occ) <= 2);

    always @(posedge axi_aclk) begin
        if (!rst_n) begin
            m_occ    <= '0;
            m_busy   <= 1'b0;
            m_len    <= '0;
            exp_req  <= 1'b0;
            exp_clr  <= 1'b0;
            exp_err  <= 1'b0;
            exp_done <= 1'b0;
            exp_blen <= '0;
            m_bursts <= '0;
            m_beats  <= '0;
        end else begin
            exp_req <= cmd_valid && (cmd_op == drain_pkg::OP_RESERVE) && !blocked && len_ok;
            exp_clr <= cmd_valid && (cmd_op == drain_pkg::OP_CLEAR_STATS) && !blocked;
            exp_err <= cmd_valid && (cmd_op != drain_pkg::OP_NOP) &&
                       (blocked || (cmd_op == drain_pkg::drain_op_e'(2'b11)) ||
                        ((cmd_op == drain_pkg::OP_RESERVE) && !len_ok));
            if (cmd_valid) exp_req_len <= cmd_len;
            if (exp_req) begin                          // Busy from the cycle after req
                m_busy <= 1'b1;
                m_len  <= exp_req_len;
            end else if (m_drain) begin
                m_busy <= 1'b0;
            end
            m_occ    <= m_occ + (AW+1)'(beat_in) - (m_drain ? (AW+1)'(m_len) : '0);
            exp_done <= m_drain;
            if (m_drain) exp_blen <= m_len;
            if (exp_clr) begin                          // Clear beats a same-cycle drain
                m_bursts <= '0;
                m_beats  <= '0;
            end else if (m_drain) begin
                m_bursts <= m_bursts + drain_pkg::BURSTS_W'(1);
                m_beats  <= m_beats + drain_pkg::BEATS_W'(m_len);
            end
        end
    end

    task automatic note_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("Fail %0t %s expected %0d got %0d", $time, sig, exp_v, act_v);
        errors++;
    endtask

    task automatic note_problem(input string what);
        $display("At %0t %s", $time, what);
        errors++;
    endtask

    // ------------------------------------------------------------------------
    // Checking assertions
    // ------------------------------------------------------------------------
    a_occ: assert property (@(posedge axi_aclk) disable iff (!rst_n) data_available == m_occ)
        else note_mismatch("data_available", 32'($sampled(m_occ)), 32'($sampled(data_available)));
    a_full: assert property (@(posedge axi_aclk) disable iff (!rst_n) wr_full == exp_full)
        else note_mismatch("wr_full", 32'($sampled(exp_full)), 32'($sampled(wr_full)));
    a_afull: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        wr_almost_full == exp_afull)
        else note_mismatch("wr_almost_full", 32'($sampled(exp_afull)),
                           32'($sampled(wr_almost_full)));
    a_empty: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        rd_empty == exp_empty)
        else note_mismatch("rd_empty", 32'($sampled(exp_empty)), 32'($sampled(rd_empty)));
    a_aempty: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        rd_almost_empty == exp_aempty)
        else note_mismatch("rd_almost_empty", 32'($sampled(exp_aempty)),
                           32'($sampled(rd_almost_empty)));
    a_ready: assert property (@(posedge axi_aclk) disable iff (!rst_n) beat_ready == !exp_full)
        else note_mismatch("beat_ready", 32'(!$sampled(exp_full)), 32'($sampled(beat_ready)));
    a_busy: assert property (@(posedge axi_aclk) disable iff (!rst_n) busy == m_busy)
        else note_mismatch("busy", 32'($sampled(m_busy)), 32'($sampled(busy)));
    a_error: assert property (@(posedge axi_aclk) disable iff (!rst_n) cmd_error == exp_err)
        else note_mismatch("cmd_error", 32'($sampled(exp_err)), 32'($sampled(cmd_error)));
    a_done: assert property (@(posedge axi_aclk) disable iff (!rst_n) burst_done == exp_done)
        else note_mismatch("burst_done", 32'($sampled(exp_done)), 32'($sampled(burst_done)));
    a_len: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        burst_done |-> (burst_len == exp_blen))
        else note_mismatch("burst_len", 32'($sampled(exp_blen)), 32'($sampled(burst_len)));
    a_bursts: assert property (@(posedge axi_aclk) disable iff (!rst_n) bursts_total == m_bursts)
        else note_mismatch("bursts_total", 32'($sampled(m_bursts)), 32'($sampled(bursts_total)));
    a_beats: assert property (@(posedge axi_aclk) disable iff (!rst_n) beats_total == m_beats)
        else note_mismatch("beats_total", $sampled(m_beats), $sampled(beats_total));
    // Beat dropped while full and nothing drains
    a_full_drop: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        (exp_full && beat_valid && !m_drain) |=> (32'(data_available) == DEPTH))
        else note_problem("a beat sent while full changed the occupancy");
    a_bound: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        32'(data_available) <= DEPTH)
        else note_problem("occupancy went beyond the FIFO, underflow or overflow");
    a_wait_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        (m_busy && (32'(m_occ) < 32'(m_len))) |=> (busy && !burst_done))
        else note_problem("a reservation completed before its beats were present");
    a_clear: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        exp_clr |=> ((bursts_total == '0) && (beats_total == '0)))
        else note_problem("clear command left the totals nonzero");
    a_nop: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        (cmd_valid && (cmd_op == drain_pkg::OP_NOP) && !m_busy) |=>
        (!cmd_error && $stable(bursts_total) && $stable(beats_total)))
        else note_problem("a no-op command changed the state");
    a_reset_state: assert property (@(posedge axi_aclk)
        $rose(rst_n) |-> (!busy && !burst_done && !cmd_error && (data_available == '0) &&
                          rd_empty && rd_almost_empty && beat_ready))
        else note_problem("outputs were not in their reset state after reset");

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic send_cmd(input drain_pkg::drain_op_e op, input int len);
        @(posedge axi_aclk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_len   <= drain_pkg::LEN_W'(len);
        @(posedge axi_aclk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int cnt;
        cnt = 0;
        while (!burst_done && !hung) begin
            @(posedge axi_aclk);
            cnt++;
            if (cnt >= limit) begin
                $display("Timed out at %0t waiting for burst_done", $time);
                hung = 1'b1;
            end
        end
    endtask

    task automatic wait_idle(input int limit);
        int cnt;
        cnt = 0;
        while (busy && !hung) begin
            @(posedge axi_aclk);
            cnt++;
            if (cnt >= limit) begin
                $display("Timed out at %0t waiting for busy to fall", $time);
                hung = 1'b1;
            end
        end
    endtask

    task automatic reserve(input int len);
        send_cmd(drain_pkg::OP_RESERVE, len);
        wait_done(300);
        wait_idle(20);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d %s finished, %0d failing checks", tests_run, name,
                 errors - test_base);
        test_base = errors;
    endtask

    initial begin
        int cnt;
        axi_aclk   = 1'b0;
        rst_n      = 1'b0;
        beat_valid = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = drain_pkg::OP_NOP;
        cmd_len    = '0;
        beat_pct   = 0;
        hung       = 1'b0;
        errors     = 0;
        test_base  = 0;
        tests_run  = 0;
        void'($urandom(32'hea02ff4d));
        repeat (5) @(posedge axi_aclk);
        rst_n <= 1'b1;

        // Fill past full then flush
        beat_pct <= 70;
        cnt = 0;
        while (!wr_full && !hung) begin
            @(posedge axi_aclk);
            cnt++;
            if (cnt >= 200) begin
                $display("Timed out at %0t waiting for wr_full", $time);
                hung = 1'b1;
            end
        end
        beat_pct <= 100;
        repeat (20) @(posedge axi_aclk);                // Beats into a full FIFO
        beat_pct <= 0;
        reserve(DEPTH);
        end_test("occupancy and flags");

        // Short of beats at request time
        repeat (2) @(posedge axi_aclk);
        send_cmd(drain_pkg::OP_RESERVE, int'(m_occ) + 5);
        repeat (10) @(posedge axi_aclk);
        beat_pct <= 40;
        wait_done(300);
        wait_idle(20);
        end_test("reservation waits for data");

        beat_pct <= 90;
        for (int i = 0; i < 8; i++) reserve(int'($urandom_range(8, 1)));
        end_test("simultaneous beat and drain");

        // Rejected commands
        beat_pct <= 0;
        repeat (2) @(posedge axi_aclk);
        send_cmd(drain_pkg::drain_op_e'(2'b11), 1);
        send_cmd(drain_pkg::OP_RESERVE, 0);
        send_cmd(drain_pkg::OP_RESERVE, DEPTH + 1);
        if (32'(m_occ) == DEPTH) reserve(1);            // Make room so the next one waits
        send_cmd(drain_pkg::OP_RESERVE, DEPTH);
        send_cmd(drain_pkg::OP_RESERVE, 1);             // While busy
        send_cmd(drain_pkg::OP_CLEAR_STATS, 0);
        beat_pct <= 60;
        wait_done(300);
        wait_idle(20);
        end_test("command errors");

        beat_pct <= 80;
        for (int i = 0; i < 5; i++) reserve(int'($urandom_range(12, 1)));
        send_cmd(drain_pkg::OP_CLEAR_STATS, 0);
        repeat (3) @(posedge axi_aclk);
        reserve(3);
        send_cmd(drain_pkg::OP_NOP, 0);
        repeat (3) @(posedge axi_aclk);
        end_test("statistics");

        // Reset with beats stored
        repeat (20) @(posedge axi_aclk);
        rst_n <= 1'b0;
        repeat (5) @(posedge axi_aclk);
        rst_n <= 1'b1;
        repeat (5) @(posedge axi_aclk);
        end_test("reset state");

        repeat (4) @(posedge axi_aclk);                 // Let pending checks finish
        $display("Tests run %0d, failing checks %0d", tests_run, errors);
        if (errors == 0 && !hung) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : drain_subsys_tb

// ==== design/drain_subsys_top.sv ====
// Write drain subsystem top
`timescale 1ns/100ps

module drain_subsys_top #(
    parameter  int DEPTH            = 64,
    parameter  int ALMOST_WR_MARGIN = 2,
    parameter  int ALMOST_RD_MARGIN = 2,
    localparam int AW               = $clog2(DEPTH)
) (
    input  logic                            axi_aclk,
    input  logic                            rst_n,
    input  logic                            beat_valid,
    input  logic                            cmd_valid,
    input  drain_pkg::drain_op_e            cmd_op,
    input  logic [drain_pkg::LEN_W-1:0]     cmd_len,
    output logic                            beat_ready,
    output logic [AW:0]                     data_available,
    output logic                            wr_full,
    output logic                            wr_almost_full,
    output logic                            rd_empty,
    output logic                            rd_almost_empty,
    output logic                            busy,
    output logic                            cmd_error,
    output logic                            burst_done,
    output logic [drain_pkg::LEN_W-1:0]     burst_len,
    output logic [drain_pkg::BURSTS_W-1:0]  bursts_total,
    output logic [drain_pkg::BEATS_W-1:0]   beats_total
);

    // ------------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------------
    logic                          req_valid;       // Decode to sequencer
    logic [drain_pkg::LEN_W-1:0]   req_len;
    logic                          clear_stats;     // Decode to result
    logic                          drain_valid;     // Sequencer to FIFO and result
    logic [drain_pkg::LEN_W-1:0]   drain_size;

    drain_cmd_decode #(
        .DEPTH (DEPTH)
    ) u_decode (
        .axi_aclk    (axi_aclk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_len     (cmd_len),
        .busy        (busy),
        .req_valid   (req_valid),
        .req_len     (req_len),
        .clear_stats (clear_stats),
        .cmd_error   (cmd_error)
    );

    drain_reserve_seq #(
        .DEPTH (DEPTH)
    ) u_seq (
        .axi_aclk       (axi_aclk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_len        (req_len),
        .data_available (data_available),
        .busy           (busy),
        .drain_valid    (drain_valid),
        .drain_size     (drain_size)
    );

    drain_ctrl #(
        .DEPTH            (DEPTH),
        .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN),
        .ALMOST_RD_MARGIN (ALMOST_RD_MARGIN)
    ) u_ctrl (
        .axi_aclk        (axi_aclk),
        .rst_n           (rst_n),
        .beat_valid      (beat_valid),
        .beat_ready      (beat_ready),
        .drain_valid     (drain_valid),
        .drain_size      (drain_size),
        .data_available  (data_available),
        .wr_full         (wr_full),
        .wr_almost_full  (wr_almost_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty)
    );

    drain_burst_result u_result (
        .axi_aclk     (axi_aclk),
        .rst_n        (rst_n),
        .drain_valid  (drain_valid),
        .drain_size   (drain_size),
        .clear_stats  (clear_stats),
        .burst_done   (burst_done),
        .burst_len    (burst_len),
        .bursts_total (bursts_total),
        .beats_total  (beats_total)
    );

endmodule : drain_subsys_top

// ==== design/drain_burst_result.sv ====
// Burst completion and statistics
`timescale 1ns/100ps

module drain_burst_result (
    input  logic                            axi_aclk,
    input  logic                            rst_n,
    input  logic                            drain_valid,   // Reservation taken this cycle
    input  logic [drain_pkg::LEN_W-1:0]     drain_size,
    input  logic                            clear_stats,
    output logic                            burst_done,
    output logic [drain_pkg::LEN_W-1:0]     burst_len,
    output logic [drain_pkg::BURSTS_W-1:0]  bursts_total,
    output logic [drain_pkg::BEATS_W-1:0]   beats_total
);

    // ------------------------------------------------------------------------
    // Completion report
    // ------------------------------------------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) burst_done <= 1'b0;
        else        burst_done <= drain_valid;
    end

    always_ff @(posedge axi_aclk) begin
        if (drain_valid) burst_len <= drain_size;          // Held until the next burst
    end

    // ------------------------------------------------------------------------
    // Totals
    // ------------------------------------------------------------------------
    // Both wrap silently, clear wins over a drain in the same cycle
    always_ff @(posedge axi_aclk) begin
        if (!rst_n || clear_stats) begin
            bursts_total <= '0;
            beats_total  <= '0;
        end else if (drain_valid) begin
            bursts_total <= bursts_total + 1'b1;
            beats_total  <= beats_total + drain_pkg::BEATS_W'(drain_size);
        end
    end

endmodule : drain_burst_result

// ==== design/drain_ctrl.sv ====
// Virtual FIFO drain control
`timescale 1ns/100ps

module drain_ctrl #(
    parameter  int DEPTH            = 64,
    parameter  int ALMOST_WR_MARGIN = 2,
    parameter  int ALMOST_RD_MARGIN = 2,
    localparam int AW               = $clog2(DEPTH)
) (
    input  logic                          axi_aclk,
    input  logic                          rst_n,
    input  logic                          beat_valid,      // One beat written
    output logic                          beat_ready,      // Not full
    input  logic                          drain_valid,     // Reserve drain_size beats
    input  logic [drain_pkg::LEN_W-1:0]   drain_size,
    output logic [AW:0]                   data_available,
    output logic                          wr_full,
    output logic                          wr_almost_full,
    output logic                          rd_empty,
    output logic                          rd_almost_empty
);

    logic [AW:0] wr_ptr;                                  // Extra bit keeps full apart from empty
    logic [AW:0] rd_ptr;
    logic [AW:0] occupancy;
    logic        beat_accept;
    logic        drain_accept;

    // ------------------------------------------------------------------------
    // Accept conditions
    // ------------------------------------------------------------------------
    assign occupancy    = wr_ptr - rd_ptr;                // Wraps cleanly, DEPTH is 2**AW
    assign beat_accept  = beat_valid && !wr_full;         // Beat while full is lost
    assign drain_accept = drain_valid && (32'(occupancy) >= 32'(drain_size));

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (beat_accept) begin
            wr_ptr <= wr_ptr + 1'b1;                      // Single beat step
        end
    end

    // Drain size never exceeds DEPTH, so it fits in AW+1 bits
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (drain_accept) begin
            rd_ptr <= rd_ptr + (AW+1)'(drain_size);       // Variable step
        end
    end

    // ------------------------------------------------------------------------
    // Flags, straight from the current pointers
    // ------------------------------------------------------------------------
    assign wr_full         = (32'(occupancy) == DEPTH);
    assign wr_almost_full  = (32'(occupancy) >= (DEPTH - ALMOST_WR_MARGIN));
    assign rd_empty        = (occupancy == '0);
    assign rd_almost_empty = (32'(occupancy) <= ALMOST_RD_MARGIN);

    assign beat_ready     = !wr_full;
    assign data_available = occupancy;

    // Pointer gap must stay within the FIFO
    a_occ_bound: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        32'(occupancy) <= DEPTH);

    // Sequencer must only ask for beats already present
    a_no_underflow: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        drain_valid |-> drain_accept);

endmodule : drain_ctrl

// ==== design/drain_reserve_seq.sv ====
// Reservation sequencer
`timescale 1ns/100ps

module drain_reserve_seq #(
    parameter  int DEPTH = 64,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic                          axi_aclk,
    input  logic                          rst_n,
    input  logic                          req_valid,       // Accepted reserve, one cycle
    input  logic [drain_pkg::LEN_W-1:0]   req_len,
    input  logic [AW:0]                   data_available,  // Current occupancy
    output logic                          busy,
    output logic                          drain_valid,
    output logic [drain_pkg::LEN_W-1:0]   drain_size
);

    drain_pkg::seq_state_e         state;
    logic [drain_pkg::LEN_W-1:0]   len_q;                  // Held reservation length
    logic                          enough_now;             // Against the incoming request
    logic                          enough_held;            // Against the held length

    assign enough_now  = (32'(data_available) >= 32'(req_len));
    assign enough_held = (32'(data_available) >= 32'(len_q));

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    // Only this block drains, so occupancy can only grow while a request waits
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            state <= drain_pkg::SEQ_IDLE;
        end else begin
            case (state)
                drain_pkg::SEQ_IDLE: begin
                    if (req_valid) begin
                        state <= enough_now ? drain_pkg::SEQ_DRAIN : drain_pkg::SEQ_WAIT;
                    end
                end
                drain_pkg::SEQ_WAIT: begin
                    if (enough_held) state <= drain_pkg::SEQ_IDLE;  // Drain issued this cycle
                end
                drain_pkg::SEQ_DRAIN: state <= drain_pkg::SEQ_IDLE;
                default:              state <= drain_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (req_valid && (state == drain_pkg::SEQ_IDLE)) len_q <= req_len;
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    assign busy        = (state != drain_pkg::SEQ_IDLE);
    assign drain_valid = (state == drain_pkg::SEQ_DRAIN) ||
                         ((state == drain_pkg::SEQ_WAIT) && enough_held);
    assign drain_size  = len_q;

    // Decoder holds back commands until busy drops
    a_no_req_busy: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        req_valid |-> !busy);

    // Pre-reservation, never drain beats that are not there
    a_drain_covered: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        drain_valid |-> (32'(data_available) >= 32'(drain_size)));

endmodule : drain_reserve_seq

// ==== design/drain_cmd_decode.sv ====
// Command decoder
`timescale 1ns/100ps

module drain_cmd_decode #(
    parameter int DEPTH = 64
) (
    input  logic                          axi_aclk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,    // One-cycle command strobe
    input  drain_pkg::drain_op_e          cmd_op,
    input  logic [drain_pkg::LEN_W-1:0]   cmd_len,
    input  logic                          busy,         // Reservation pending
    output logic                          req_valid,
    output logic [drain_pkg::LEN_W-1:0]   req_len,
    output logic                          clear_stats,
    output logic                          cmd_error
);

    logic blocked;                                      // Cannot take a new command
    logic len_zero;
    logic len_big;
    logic nxt_req;
    logic nxt_clr;
    logic nxt_err;

    // A request issued last cycle has not reached busy yet
    assign blocked  = busy || req_valid;
    assign len_zero = (cmd_len == '0);
    assign len_big  = (32'(cmd_len) > DEPTH);           // More than the FIFO can ever hold

    // ------------------------------------------------------------------------
    // Outcome select, at most one per command
    // ------------------------------------------------------------------------
    always_comb begin
        nxt_req = 1'b0;
        nxt_clr = 1'b0;
        nxt_err = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                drain_pkg::OP_NOP: begin
                    // Nothing to do
                end
                drain_pkg::OP_RESERVE: begin
                    if (blocked || len_zero || len_big) nxt_err = 1'b1;
                    else                                nxt_req = 1'b1;
                end
                drain_pkg::OP_CLEAR_STATS: begin
                    if (blocked) nxt_err = 1'b1;
                    else         nxt_clr = 1'b1;
                end
                default: nxt_err = 1'b1;                // Unassigned opcode
            endcase
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            req_valid   <= 1'b0;
            clear_stats <= 1'b0;
            cmd_error   <= 1'b0;
        end else begin
            req_valid   <= nxt_req;
            clear_stats <= nxt_clr;
            cmd_error   <= nxt_err;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (nxt_req) req_len <= cmd_len;                // Length travels with the request
    end

    // One outcome per decoded command
    a_one_outcome: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        $onehot0({req_valid, clear_stats, cmd_error}));

endmodule : drain_cmd_decode

// ==== design/drain_pkg.sv ====
// Drain subsystem shared types
package drain_pkg;

    // ------------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------------
    localparam int LEN_W    = 8;                    // Burst length, same as drain size
    localparam int BURSTS_W = 16;                   // Completed burst counter
    localparam int BEATS_W  = 32;                   // Drained beat counter

    // ------------------------------------------------------------------------
    // Command opcodes
    // ------------------------------------------------------------------------
    // Code 2'b11 has no name and is rejected by the decoder
    typedef enum logic [1:0] {
        OP_NOP         = 2'b00,                     // No action
        OP_RESERVE     = 2'b01,                     // Reserve cmd_len beats
        OP_CLEAR_STATS = 2'b10                      // Zero both totals
    } drain_op_e;

    // ------------------------------------------------------------------------
    // Reservation sequencer states
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'b00,                          // Nothing pending
        SEQ_WAIT  = 2'b01,                          // Holding length, short of beats
        SEQ_DRAIN = 2'b10                           // Beats already there at request
    } seq_state_e;

endpackage : drain_pkg
